// ==== src/fetch_settings.svh ====
// Build-time constants for the fetch front end, included by the RTL and the testbench
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// First fetch address after reset
`define FETCH_RESET_VEC 32'h0000_0000

// Scratch memory depth in 32-bit words
`define SCRATCH_WORDS 256

// Branch target buffer entries, power of two
`define BTB_ENTRIES 16

// Address bits 31:28 that select the external fetch port
`define EXT_REGION_TAG 4'h8

// In-flight fetch records
`define TRACK_DEPTH 2

`endif

// ==== src/fetch_pkg.sv ====
// Shared fetch front end types, imported by every RTL block and the testbench
package fetch_pkg;

    // Sub-unit that owns a fetch
    typedef enum logic {
        UNIT_SCRATCH = 1'b0,
        UNIT_EXT     = 1'b1
    } unit_sel_t;

    // Back end redirect, wins over everything
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    // BTB training from branch resolution
    typedef struct packed {
        logic        valid;
        logic        taken;
        logic [31:0] pc;
        logic [31:0] target;
    } btb_update_t;

    // Request into a sub-unit, word aligned
    typedef struct packed {
        logic [31:0] addr;
    } fetch_req_t;

    // One in-flight fetch
    typedef struct packed {
        unit_sel_t   unit;
        logic [31:0] pc;
    } track_entry_t;

    // Completed fetch to the decode stage
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_out_t;

endpackage

// ==== src/pc_select.sv ====
// Fetch pc register and next-pc priority mux, instantiated once by fetch_unit
`timescale 1ns/1ps
`include "fetch_settings.svh"

module pc_select (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue,
    input  fetch_pkg::redirect_t redirect,
    input  logic                 predict_valid,
    input  logic [31:0]          predict_pc,
    output logic [31:0]          pc,
    output logic [31:0]          next_pc
);

    logic [31:0] next_pc_raw;

    //////////////////////////////////////////////////////////////////////
    // Next pc
    //////////////////////////////////////////////////////////////////////
    // Redirect, then BTB hit, then fall through
    always_comb begin
        if (redirect.valid) begin
            next_pc_raw = redirect.pc;
        end else if (predict_valid) begin
            next_pc_raw = predict_pc;
        end else begin
            next_pc_raw = pc + 32'd4;
        end
    end

    // Low bits dropped, no compressed support
    assign next_pc = {next_pc_raw[31:2], 2'b00};

    //////////////////////////////////////////////////////////////////////
    // Pc register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `FETCH_RESET_VEC;
        end else if (issue || redirect.valid) begin
            pc <= next_pc;
        end
    end

    // Also catches a misaligned reset vector
    pc_aligned_a : assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00);

endmodule

// ==== src/branch_target_buffer.sv ====
// Direct-mapped BTB, looked up combinationally on the fetch pc, trained by the back end
`timescale 1ns/1ps
`include "fetch_settings.svh"

module branch_target_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            pc,
    input  fetch_pkg::btb_update_t btb_update,
    output logic                   predict_valid,
    output logic [31:0]            predict_pc
);

    localparam int IDX_W = $clog2(`BTB_ENTRIES);
    localparam int TAG_W = 30 - IDX_W;

    // Tag and target stored side by side
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [31:0]      target;
    } btb_entry_t;

    logic [`BTB_ENTRIES-1:0] entry_valid;
    btb_entry_t              table_mem [`BTB_ENTRIES];

    logic [IDX_W-1:0] lookup_idx;
    logic [TAG_W-1:0] lookup_tag;
    logic [IDX_W-1:0] update_idx;
    logic [TAG_W-1:0] update_tag;
    btb_entry_t       lookup_entry;

    // Word index below, tag above
    assign lookup_idx = pc[IDX_W+1:2];
    assign lookup_tag = pc[31:IDX_W+2];
    assign update_idx = btb_update.pc[IDX_W+1:2];
    assign update_tag = btb_update.pc[31:IDX_W+2];

    //////////////////////////////////////////////////////////////////////
    // Lookup
    //////////////////////////////////////////////////////////////////////
    assign lookup_entry  = table_mem[lookup_idx];
    assign predict_valid = entry_valid[lookup_idx] && (lookup_entry.tag == lookup_tag);
    assign predict_pc    = lookup_entry.target;

    //////////////////////////////////////////////////////////////////////
    // Training
    //////////////////////////////////////////////////////////////////////
    // Taken writes the entry
    always_ff @(posedge clk) begin
        if (btb_update.valid && btb_update.taken) begin
            table_mem[update_idx] <= '{tag: update_tag, target: btb_update.target};
        end
    end

    // Not taken kills only a matching entry
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else if (btb_update.valid) begin
            if (btb_update.taken) begin
                entry_valid[update_idx] <= 1'b1;
            end else if (table_mem[update_idx].tag == update_tag) begin
                entry_valid[update_idx] <= 1'b0;
            end
        end
    end

endmodule

// ==== src/fetch_track_fifo.sv ====
// Flushable queue of in-flight fetch records, keeps completions in issue order
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_track_fifo (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    push,
    input  fetch_pkg::track_entry_t push_data,
    input  logic                    pop,
    output fetch_pkg::track_entry_t head,
    output logic                    empty,
    output logic                    full
);

    import fetch_pkg::*;

    localparam int PTR_W = (`TRACK_DEPTH > 1) ? $clog2(`TRACK_DEPTH) : 1;
    localparam int CNT_W = $clog2(`TRACK_DEPTH + 1);

    track_entry_t     entries [`TRACK_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // Wrap for depths that are not powers of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`TRACK_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Payload only
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and count
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop) rd_ptr <= ptr_next(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    assign head  = entries[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(`TRACK_DEPTH));

    // Issue must stall on full, sub-units never answer unasked
    no_push_full_a : assert property (@(posedge clk) disable iff (rst || flush)
        !(push && full && !pop));
    no_pop_empty_a : assert property (@(posedge clk) disable iff (rst || flush)
        !(pop && empty));

endmodule

// ==== src/inst_scratch_mem.sv ====
// On-chip instruction scratch memory, one cycle read latency, preloaded through the load port
`timescale 1ns/1ps
`include "fetch_settings.svh"

module inst_scratch_mem (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  new_request,
    input  fetch_pkg::fetch_req_t req,
    input  logic                  flush,
    input  logic                  load_en,
    input  logic [31:0]           load_addr,
    input  logic [31:0]           load_data,
    output logic                  ready,
    output logic                  data_valid,
    output logic [31:0]           data_out
);

    localparam int IDX_W = $clog2(`SCRATCH_WORDS);

    logic [31:0] mem [`SCRATCH_WORDS];
    logic        read_pending;

    // Load port, address wraps on depth
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[IDX_W+1:2]] <= load_data;
        end
    end

    // Synchronous read
    always_ff @(posedge clk) begin
        if (new_request) begin
            data_out <= mem[req.addr[IDX_W+1:2]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_pending <= 1'b0;
        end else begin
            read_pending <= new_request && !flush;
        end
    end

    // Redirect in the return cycle kills the word
    assign data_valid = read_pending && !flush;
    assign ready      = 1'b1;

endmodule

// ==== src/ext_fetch_port.sv ====
// Bridge to the external fetch bus for the upper region, one request outstanding at most
`timescale 1ns/1ps

module ext_fetch_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  new_request,
    input  fetch_pkg::fetch_req_t req,
    input  logic                  flush,
    output logic                  ext_req,
    output logic [31:0]           ext_addr,
    input  logic                  ext_rvalid,
    input  logic [31:0]           ext_rdata,
    output logic                  ready,
    output logic                  data_valid,
    output logic [31:0]           data_out
);

    logic busy;
    logic drop;
    logic resp_valid;

    //////////////////////////////////////////////////////////////////////
    // Request side
    //////////////////////////////////////////////////////////////////////
    // Strobe goes out in the issue cycle
    assign ext_req  = new_request;
    assign ext_addr = req.addr;

    // Busy until the bus answers, flushed or not
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (new_request) begin
            busy <= 1'b1;
        end else if (ext_rvalid) begin
            busy <= 1'b0;
        end
    end

    // Orphaned response after a redirect
    always_ff @(posedge clk) begin
        if (rst) begin
            drop <= 1'b0;
        end else if (ext_rvalid) begin
            drop <= 1'b0;
        end else if (flush && busy) begin
            drop <= 1'b1;
        end
    end

    assign ready = !busy;

    //////////////////////////////////////////////////////////////////////
    // Response side
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (ext_rvalid) begin
            data_out <= ext_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= ext_rvalid && !drop && !flush;
        end
    end

    // Late redirect still wins
    assign data_valid = resp_valid && !flush;

    // Bus model must not answer without a request
    rvalid_when_busy_a : assert property (@(posedge clk) disable iff (rst)
        ext_rvalid |-> busy);

endmodule

// ==== src/fetch_unit.sv ====
// Fetch front end top, joins pc select, BTB, tracking queue and both memory sub-units
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst,

    // Back end control
    input  fetch_pkg::redirect_t   redirect,
    input  fetch_pkg::btb_update_t btb_update,
    input  logic                   pc_id_available,
    output logic                   pc_id_assigned,

    // Completion
    output logic                   fetch_complete,
    output fetch_pkg::fetch_out_t  fetch_out,

    // Scratch preload
    input  logic                   load_en,
    input  logic [31:0]            load_addr,
    input  logic [31:0]            load_data,

    // External bus
    output logic                   ext_req,
    output logic [31:0]            ext_addr,
    input  logic                   ext_rvalid,
    input  logic [31:0]            ext_rdata
);

    import fetch_pkg::*;

    logic [31:0]  pc;
    logic [31:0]  next_pc;
    logic         predict_valid;
    logic [31:0]  predict_pc;
    logic         issue;
    logic         flush;
    unit_sel_t    unit_sel;
    fetch_req_t   req;
    track_entry_t track_push;
    track_entry_t track_head;
    logic         track_empty;
    logic         track_full;

    // Sub-unit handshake
    logic         scratch_ready;
    logic         scratch_valid;
    logic [31:0]  scratch_data;
    logic         ext_ready;
    logic         ext_valid;
    logic [31:0]  ext_data;

    //////////////////////////////////////////////////////////////////////
    // Pc and prediction
    //////////////////////////////////////////////////////////////////////
    pc_select pc_select_i (
        .clk, .rst, .issue, .redirect,
        .predict_valid, .predict_pc, .pc, .next_pc
    );

    branch_target_buffer btb_i (
        .clk, .rst, .pc, .btb_update, .predict_valid, .predict_pc
    );

    //////////////////////////////////////////////////////////////////////
    // Issue and dispatch
    //////////////////////////////////////////////////////////////////////
    assign flush    = redirect.valid;
    assign unit_sel = (pc[31:28] == `EXT_REGION_TAG) ? UNIT_EXT : UNIT_SCRATCH;
    assign req      = '{addr: pc};

    // Both units ready keeps completions in order
    assign issue = pc_id_available && scratch_ready && ext_ready && !track_full && !flush;
    assign pc_id_assigned = issue;

    assign track_push = '{unit: unit_sel, pc: pc};

    fetch_track_fifo track_i (
        .clk, .rst, .flush,
        .push      (issue),
        .push_data (track_push),
        .pop       (fetch_complete),
        .head      (track_head),
        .empty     (track_empty),
        .full      (track_full)
    );

    inst_scratch_mem scratch_i (
        .clk, .rst,
        .new_request (issue && (unit_sel == UNIT_SCRATCH)),
        .req, .flush,
        .load_en, .load_addr, .load_data,
        .ready       (scratch_ready),
        .data_valid  (scratch_valid),
        .data_out    (scratch_data)
    );

    ext_fetch_port ext_i (
        .clk, .rst,
        .new_request (issue && (unit_sel == UNIT_EXT)),
        .req, .flush,
        .ext_req, .ext_addr, .ext_rvalid, .ext_rdata,
        .ready       (ext_ready),
        .data_valid  (ext_valid),
        .data_out    (ext_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Completion
    //////////////////////////////////////////////////////////////////////
    // Head of queue names the owner and the pc
    assign fetch_complete = scratch_valid || ext_valid;
    assign fetch_out.pc   = track_head.pc;
    assign fetch_out.inst = (track_head.unit == UNIT_EXT) ? ext_data : scratch_data;

    // Every completion has a record
    complete_tracked_a : assert property (@(posedge clk) disable iff (rst)
        fetch_complete |-> !track_empty);

    // Never two sub-units answering in one cycle
    single_owner_a : assert property (@(posedge clk) disable iff (rst)
        !(scratch_valid && ext_valid));

endmodule

// ==== test/fetch_tb.sv ====
// Self-checking testbench for fetch_unit, with an external bus model and a reference model
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_tb;

    import fetch_pkg::*;

    localparam int MEM_IDX_W = $clog2(`SCRATCH_WORDS);
    localparam int BTB_IDX_W = $clog2(`BTB_ENTRIES);
    // Cycles with pc_id_available high over all tests, rounded up
    localparam int FETCH_CYCLES = 140;
    // Worst case every fetch waits a full bus latency, plus load and drain time
    localparam int WATCHDOG_CYCLES = `SCRATCH_WORDS + 50 + FETCH_CYCLES * 9 + 12 * 100;

    // One expected completion
    typedef struct packed {
        fetch_out_t  out;
        unit_sel_t   unit;
        logic [31:0] issue_cycle;
    } expect_t;

    logic        clk;
    logic        rst;
    redirect_t   redirect;
    btb_update_t btb_update;
    logic        pc_id_available;
    logic        pc_id_assigned;
    logic        fetch_complete;
    fetch_out_t  fetch_out;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        ext_req;
    logic [31:0] ext_addr;
    logic        ext_rvalid;
    logic [31:0] ext_rdata;

    // Reference model state
    logic [31:0] shadow_mem [`SCRATCH_WORDS];
    logic [31:0] shadow_pc;
    logic        shadow_btb_valid [`BTB_ENTRIES];
    logic [31:0] shadow_btb_pc [`BTB_ENTRIES];
    logic [31:0] shadow_btb_target [`BTB_ENTRIES];
    expect_t     exp_q [$];

    logic [31:0] lfsr_state;
    int          cycle = 0;
    int          last_rvalid_cycle = 0;
    int          issue_count = 0;
    int          completion_count = 0;
    int          check_count = 0;
    int          mismatch_count = 0;
    int          other_errors = 0;

    fetch_unit fetch_unit_i (
        .clk, .rst, .redirect, .btb_update, .pc_id_available, .pc_id_assigned,
        .fetch_complete, .fetch_out, .load_en, .load_addr, .load_data,
        .ext_req, .ext_addr, .ext_rvalid, .ext_rdata
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    // Galois step, right shifting
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // External memory contents, scrambled from the full address
    function automatic logic [31:0] ext_word(input logic [31:0] addr);
        logic [31:0] s;
        s = addr ^ 32'hed0f_6834;
        for (int i = 0; i < 32; i++) begin
            s = lfsr_next(s);
        end
        return s;
    endfunction

    function automatic unit_sel_t ref_unit(input logic [31:0] pc);
        return (pc[31:28] == `EXT_REGION_TAG) ? UNIT_EXT : UNIT_SCRATCH;
    endfunction

    function automatic logic [31:0] ref_inst(input logic [31:0] pc);
        if (ref_unit(pc) == UNIT_EXT) begin
            return ext_word(pc);
        end
        return shadow_mem[pc[MEM_IDX_W+1:2]];
    endfunction

    // Taken hit wins over fall through
    function automatic logic [31:0] ref_next_pc(input logic [31:0] pc);
        logic [BTB_IDX_W-1:0] idx;
        idx = pc[BTB_IDX_W+1:2];
        if (shadow_btb_valid[idx] && shadow_btb_pc[idx][31:2] == pc[31:2]) begin
            return {shadow_btb_target[idx][31:2], 2'b00};
        end
        return pc + 32'd4;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        check_count++;
        if (got !== want) begin
            mismatch_count++;
            $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, want);
        end
    endtask

    task automatic report_error(input string msg);
        other_errors++;
        $display("ERROR time=%0t %s", $time, msg);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Clock, cycle count, watchdog
    //////////////////////////////////////////////////////////////////////
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR time=%0t watchdog expired, the run did not finish", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // External bus model
    //////////////////////////////////////////////////////////////////////
    // One request at a time, 1 to 6 cycles to answer
    initial begin
        int          latency;
        logic [31:0] addr;
        ext_rvalid = 1'b0;
        ext_rdata  = '0;
        forever begin
            @(negedge clk);
            if (!rst && ext_req) begin
                addr    = ext_addr;
                latency = 1 + int'(random_bits(3) % 32'd6);
                repeat (latency) @(posedge clk);
                #2;
                ext_rvalid = 1'b1;
                ext_rdata  = ext_word(addr);
                @(posedge clk);
                #2;
                ext_rvalid = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and compare
    //////////////////////////////////////////////////////////////////////
    // Sampled mid cycle, inputs and outputs settled
    always @(negedge clk) begin
        expect_t e;
        if (!rst) begin
            // Completion against oldest expectation
            if (fetch_complete) begin
                completion_count++;
                if (exp_q.size() == 0) begin
                    report_error("fetch_complete with no fetch in flight");
                end else begin
                    e = exp_q.pop_front();
                    check_value("fetch_out.pc", 64'(fetch_out.pc), 64'(e.out.pc));
                    check_value("fetch_out.inst", 64'(fetch_out.inst), 64'(e.out.inst));
                    if (e.unit == UNIT_SCRATCH) begin
                        check_value("scratch completion cycle", 64'(cycle),
                                    64'(e.issue_cycle + 1));
                    end else begin
                        check_value("ext completion cycle", 64'(cycle),
                                    64'(last_rvalid_cycle + 1));
                    end
                end
            end
            if (pc_id_assigned && !pc_id_available) begin
                report_error("pc_id_assigned while pc_id_available is low");
            end
            // Issue side
            if (redirect.valid) begin
                check_value("pc_id_assigned", 64'(pc_id_assigned), 64'(0));
                check_value("fetch_complete", 64'(fetch_complete), 64'(0));
                exp_q.delete();
                shadow_pc = {redirect.pc[31:2], 2'b00};
            end else if (pc_id_assigned) begin
                issue_count++;
                e.out.pc      = shadow_pc;
                e.out.inst    = ref_inst(shadow_pc);
                e.unit        = ref_unit(shadow_pc);
                e.issue_cycle = 32'(cycle);
                check_value("ext_req", 64'(ext_req), 64'(e.unit == UNIT_EXT));
                if (e.unit == UNIT_EXT) begin
                    check_value("ext_addr", 64'(ext_addr), 64'(shadow_pc));
                end
                exp_q.push_back(e);
                shadow_pc = ref_next_pc(shadow_pc);
            end else begin
                check_value("ext_req", 64'(ext_req), 64'(0));
            end
            if (ext_rvalid) begin
                last_rvalid_cycle = cycle;
            end
            // Training lands after this cycle's lookup
            if (btb_update.valid) begin
                if (btb_update.taken) begin
                    shadow_btb_valid[btb_update.pc[BTB_IDX_W+1:2]]  = 1'b1;
                    shadow_btb_pc[btb_update.pc[BTB_IDX_W+1:2]]     = btb_update.pc;
                    shadow_btb_target[btb_update.pc[BTB_IDX_W+1:2]] = btb_update.target;
                end else if (shadow_btb_pc[btb_update.pc[BTB_IDX_W+1:2]][31:2]
                             == btb_update.pc[31:2]) begin
                    shadow_btb_valid[btb_update.pc[BTB_IDX_W+1:2]] = 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////////////////////////
    // Inputs change 2 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic load_scratch();
        logic [31:0] word;
        for (int i = 0; i < `SCRATCH_WORDS; i++) begin
            word          = random_bits(32);
            load_en       = 1'b1;
            load_addr     = 32'(i) << 2;
            load_data     = word;
            shadow_mem[i] = word;
            step_cycle();
        end
        load_en = 1'b0;
    endtask

    task automatic send_redirect(input logic [31:0] target);
        redirect = '{valid: 1'b1, pc: target};
        step_cycle();
        redirect = '0;
    endtask

    task automatic train_btb(input logic [31:0] pc, input logic [31:0] target,
                             input logic taken);
        btb_update = '{valid: 1'b1, taken: taken, pc: pc, target: target};
        step_cycle();
        btb_update = '0;
    endtask

    // Random gaps leave pc_id_available low about a quarter of the time
    task automatic run_fetch(input int cycles, input logic gaps);
        for (int i = 0; i < cycles; i++) begin
            pc_id_available = gaps ? (random_bits(2) != 32'd0) : 1'b1;
            step_cycle();
        end
        pc_id_available = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 100) begin
            step_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_error("fetches still in flight after 100 cycles");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        int held_issues;
        int held_completions;
        lfsr_state      = 32'hed0f_6834;
        rst             = 1'b1;
        redirect        = '0;
        btb_update      = '0;
        pc_id_available = 1'b0;
        load_en         = 1'b0;
        load_addr       = '0;
        load_data       = '0;
        shadow_pc       = `FETCH_RESET_VEC;
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            shadow_btb_valid[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        load_scratch();

        // Straight line from the reset vector
        run_fetch(20, 1'b0);
        wait_idle();

        // External region, then scratch to external and back
        send_redirect(32'h8000_0100);
        run_fetch(20, 1'b1);
        wait_idle();
        send_redirect(32'h7fff_fff0);
        run_fetch(20, 1'b1);
        wait_idle();
        send_redirect(32'h8fff_fff4);
        run_fetch(15, 1'b0);
        wait_idle();

        // Redirects over live scratch and external fetches
        pc_id_available = 1'b1;
        repeat (3) step_cycle();
        send_redirect(32'h8000_0400);
        repeat (4) step_cycle();
        send_redirect(32'h0000_0040);
        run_fetch(6, 1'b0);
        wait_idle();

        // Taken entry jumps, not-taken entry falls through again
        train_btb(32'h0000_0108, 32'h0000_0200, 1'b1);
        send_redirect(32'h0000_0100);
        run_fetch(10, 1'b0);
        wait_idle();
        train_btb(32'h0000_0108, 32'h0000_0200, 1'b0);
        send_redirect(32'h0000_0100);
        run_fetch(10, 1'b0);
        wait_idle();

        // Hold off issue, then pick up at the same pc
        send_redirect(32'h0000_0300);
        run_fetch(6, 1'b0);
        wait_idle();
        held_issues      = issue_count;
        held_completions = completion_count;
        repeat (10) step_cycle();
        check_value("pc_id_assigned count", 64'(issue_count), 64'(held_issues));
        check_value("fetch_complete count", 64'(completion_count), 64'(held_completions));
        run_fetch(6, 1'b0);
        wait_idle();

        $display("Checks %0d, value mismatches %0d, other errors %0d",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+src
src/fetch_pkg.sv
src/pc_select.sv
src/branch_target_buffer.sv
src/fetch_track_fifo.sv
src/inst_scratch_mem.sv
src/ext_fetch_port.sv
src/fetch_unit.sv
test/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f files.f \
        --top-module fetch_tb -o fetch_sim \
    && ./obj_dir/fetch_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
